// File: project.f
sc_pkg.sv
link_pkg.sv
serial_value_rx.sv
sng_bank.sv
sc_integrator.sv
integrator_chain.sv
ode_pair.sv
snapshot_tx.sv
sc_top.sv
sc_top_properties.sv
tb_sc_top.sv

// File: Makefile
SIM := obj_dir/Vtb_sc_top

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log; cat sim.log
	grep -q "all tests passed" sim.log

$(SIM): project.f $(shell cat project.f)
	verilator --binary --timing --assert --top-module tb_sc_top -f project.f

clean:
	rm -rf obj_dir sim.log

// File: tb_sc_top.sv
// Directed testbench for sc_top that frames inputs, decodes every snapshot lane and checks each behavior
`timescale 1ns/1ps

module tb_sc_top;
    import sc_pkg::*;
    import link_pkg::*;

    localparam int PERIOD   = 40;
    localparam int RST_CYC  = 8;
    localparam int SETTLE   = 4;                // Frames until new inputs reach every snapshot
    localparam int FRAMES   = 165;              // Frames decoded over all tests
    localparam int LIMIT_NS = (FRAMES * FRAME_LEN + 2 * RST_CYC + 200) * PERIOD;

    logic       clk;
    logic       rst_n;
    logic       in_a_rx;
    logic       in_b_rx;
    logic [4:0] tx_bits;                        // Lanes chain_a, chain_b, chain_c, y1, y2
    logic       chain_c_bit;

    int     cyc = 0;                            // Edges since reset release
    int     next_frame = 0;
    int     drv_slot;
    int     errors = 0;
    int     tests_run = 0;
    int     bad_tests = 0;
    int     seed = 35;
    value_t drive_a = '0;                       // Words the input driver sends
    value_t drive_b = '0;
    value_t cur_a = '0;                         // Word held for the frame in flight
    value_t cur_b = '0;
    value_t rx_val [5];                         // Last decoded frame per lane
    logic   rx_gap [5];
    value_t y1_ref [20];
    value_t y2_ref [20];

    sc_top uut (
        .clk(clk), .rst_n(rst_n), .in_a_rx(in_a_rx), .in_b_rx(in_b_rx),
        .chain_a_tx(tx_bits[0]), .chain_b_tx(tx_bits[1]), .chain_c_tx(tx_bits[2]),
        .y1_tx(tx_bits[3]), .y2_tx(tx_bits[4]), .chain_c_bit(chain_c_bit)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Edge 10n+k+1 after release carries slot k of frame n
    always @(posedge clk) begin
        if (rst_n) cyc <= 0;
        else cyc <= cyc + 1;
    end

    // Bit k of the held word goes out for the receiver's slot k
    always @(posedge clk) begin
        drv_slot = rst_n ? 0 : (cyc + 1) % FRAME_LEN;
        if (drv_slot == 0) begin
            cur_a   <= drive_a;
            cur_b   <= drive_b;
            in_a_rx <= drive_a[0];
            in_b_rx <= drive_b[0];
        end else begin
            in_a_rx <= (drv_slot == GAP_SLOT) ? 1'b0 : cur_a[drv_slot];   // Gap sends 0
            in_b_rx <= (drv_slot == GAP_SLOT) ? 1'b0 : cur_b[drv_slot];
        end
    end

    function automatic string lane_name(int i);
        case (i)
            0: return "chain_a";
            1: return "chain_b";
            2: return "chain_c";
            3: return "y1";
            default: return "y2";
        endcase
    endfunction

    task automatic fail_value(string name, int got, int exp);
        $display("Fail %0t %s: got %0d, reference %0d", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_test(string name, int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            bad_tests++;
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    // Holds reset for RST_CYC cycles while all six outputs stay low
    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (RST_CYC) begin
            @(negedge clk);
            if ({tx_bits, chain_c_bit} != 6'b0)
                fail_value("outputs in reset", int'({tx_bits, chain_c_bit}), 0);
        end
        @(posedge clk);
        rst_n <= 1'b0;
        next_frame = 0;
    endtask

    // Decodes frame next_frame on all lanes at the falling edges
    task automatic get_frame();
        int base;
        base = next_frame * FRAME_LEN + 1;
        @(negedge clk);
        while (cyc < base) @(negedge clk);
        if (cyc != base) begin
            $display("Frame %0d was missed, decoder reached cycle %0d", next_frame, cyc);
            errors++;
        end
        for (int k = 0; k < FRAME_LEN; k++) begin
            if (k > 0) @(negedge clk);
            for (int i = 0; i < 5; i++) begin
                if (k < VALUE_W) rx_val[i][k] = tx_bits[i];     // LSB first
                else rx_gap[i] = tx_bits[i];
            end
        end
        next_frame++;
    endtask

    task automatic reset_state();
        int e0;
        e0 = errors;
        apply_reset();
        get_frame();
        for (int i = 0; i < 5; i++) begin
            if (rx_val[i] != '0) fail_value(lane_name(i), int'(rx_val[i]), 0);
        end
        y1_ref[0] = rx_val[3];
        y2_ref[0] = rx_val[4];
        report_test("reset_state", e0);
    endtask

    task automatic frame_format();
        int e0;
        e0 = errors;
        for (int f = 1; f <= 20; f++) begin
            get_frame();
            for (int i = 0; i < 5; i++) begin
                if (rx_gap[i] !== 1'b0) fail_value({lane_name(i), " gap"}, int'(rx_gap[i]), 0);
                if ($isunknown(rx_val[i])) begin
                    $display("%s frame %0d decoded with unknown bits",
                             lane_name(i), next_frame - 1);
                    errors++;
                end
            end
            if (f < 20) begin
                y1_ref[f] = rx_val[3];
                y2_ref[f] = rx_val[4];
            end
        end
        report_test("frame_format", e0);
    endtask

    task automatic chain_growth();
        int     e0;
        value_t prev [3];
        value_t start_a;
        e0 = errors;
        for (int i = 0; i < 3; i++) prev[i] = rx_val[i];
        for (int f = 0; f < 10; f++) begin
            get_frame();
            for (int i = 0; i < 3; i++) begin
                if (rx_val[i] < prev[i]) fail_value(lane_name(i), int'(rx_val[i]), int'(prev[i]));
                prev[i] = rx_val[i];
            end
        end
        drive_a = value_t'(128 + $unsigned($random(seed)) % 384);   // Big enough to show a rise
        drive_b = '0;
        repeat (SETTLE) get_frame();
        get_frame();
        start_a = rx_val[0];
        prev[0] = start_a;
        for (int f = 1; f < 30; f++) begin
            get_frame();
            if (rx_val[0] < prev[0]) fail_value("chain_a", int'(rx_val[0]), int'(prev[0]));
            prev[0] = rx_val[0];
        end
        if (prev[0] <= start_a) fail_value("chain_a end", int'(prev[0]), int'(start_a));
        report_test("chain_growth", e0);
    endtask

    task automatic decay();
        int     e0;
        bit     hit_zero;
        value_t prev [3];
        e0 = errors;
        hit_zero = 1'b0;
        drive_a = '0;
        drive_b = 9'd511;
        repeat (SETTLE) get_frame();
        get_frame();
        for (int i = 0; i < 3; i++) prev[i] = rx_val[i];
        for (int f = 1; f < 60; f++) begin
            get_frame();
            for (int i = 0; i < 3; i++) begin
                if (rx_val[i] > prev[i]) fail_value(lane_name(i), int'(rx_val[i]), int'(prev[i]));
                prev[i] = rx_val[i];
            end
            if (hit_zero && rx_val[0] != '0) fail_value("chain_a at 0", int'(rx_val[0]), 0);
            hit_zero = hit_zero || (rx_val[0] == '0);
            // Stream of a zero count never fires
            if (rx_val[2] == '0 && chain_c_bit !== 1'b0)
                fail_value("chain_c_bit", int'(chain_c_bit), 0);
        end
        if (!hit_zero) begin
            $display("chain_a never reached 0 within 60 frames of decay");
            errors++;
        end
        report_test("decay", e0);
    endtask

    task automatic freeze();
        int     e0;
        value_t prev [3];
        e0 = errors;
        drive_a = '0;
        drive_b = '0;
        repeat (SETTLE) get_frame();
        get_frame();
        for (int i = 0; i < 3; i++) prev[i] = rx_val[i];
        for (int f = 1; f < 12; f++) begin
            get_frame();
            for (int i = 0; i < 3; i++) begin
                if (rx_val[i] != prev[i]) fail_value(lane_name(i), int'(rx_val[i]), int'(prev[i]));
            end
        end
        report_test("freeze", e0);
    endtask

    // Pair sees only the LFSR, so a reset replays the same frames
    task automatic ode_independence();
        int e0;
        e0 = errors;
        drive_a = value_t'($random(seed));
        drive_b = value_t'($random(seed));
        apply_reset();
        for (int f = 0; f < 20; f++) begin
            get_frame();
            if (rx_val[3] != y1_ref[f])
                fail_value($sformatf("y1 frame %0d", f), int'(rx_val[3]), int'(y1_ref[f]));
            if (rx_val[4] != y2_ref[f])
                fail_value($sformatf("y2 frame %0d", f), int'(rx_val[4]), int'(y2_ref[f]));
            if (f == 9) begin
                drive_a = value_t'($random(seed));
                drive_b = value_t'($random(seed));
            end
        end
        report_test("ode_independence", e0);
    endtask

    initial begin
        rst_n   = 1'b1;
        in_a_rx = 1'b0;
        in_b_rx = 1'b0;
        reset_state();
        frame_format();
        chain_growth();
        decay();
        freeze();
        ode_independence();
        $display("%0d tests run, %0d with errors, %0d errors in total", tests_run, bad_tests, errors);
        if (errors == 0) $display("all tests passed");
        else $display("tests failed");
        $finish;
    end

    // Watchdog sized from the frame count of all tests
    initial begin
        #(LIMIT_NS);
        $display("Timeout after %0d ns, the run did not complete", LIMIT_NS);
        $display("tests failed");
        $finish;
    end

endmodule

// File: sc_top_properties.sv
// Concurrent checks on the snapshot transmitter, bound into every snapshot_tx instance
`timescale 1ns/1ps

module snapshot_tx_props (
    input logic                         clk,
    input logic                         rst_n,
    input logic [link_pkg::SLOT_W-1:0]  slot_cnt,
    input logic [link_pkg::SNAP_W-1:0]  snap_cnt,
    input logic [4:0]                   tx_q,
    input logic [5*sc_pkg::VALUE_W-1:0] snap_all    // All five snapshot registers
);
    import link_pkg::*;

    // Every lane sends 0 for the gap slot
    assert property (@(posedge clk) disable iff (rst_n)
        slot_cnt == SLOT_W'(GAP_SLOT) |=> tx_q == '0)
        else $error("serial output high after the gap slot");

    assert property (@(posedge clk) disable iff (rst_n) slot_cnt < SLOT_W'(FRAME_LEN))
        else $error("slot counter out of range");

    // Captures only on the edge where the snapshot counter is 0
    assert property (@(posedge clk) disable iff (rst_n)
        !$stable(snap_all) |-> $past(snap_cnt) == '0)
        else $error("snapshot register changed outside a capture");

endmodule

bind snapshot_tx snapshot_tx_props u_props (
    .clk(clk), .rst_n(rst_n), .slot_cnt(slot_cnt), .snap_cnt(snap_cnt), .tx_q(tx_q),
    .snap_all({snap_reg[4], snap_reg[3], snap_reg[2], snap_reg[1], snap_reg[0]})
);

// File: sc_top.sv
// Top level of the stochastic integrator, from serial inputs to serial snapshot outputs
`timescale 1ns/1ps

module sc_top (
    input  logic clk,
    input  logic rst_n,
    input  logic in_a_rx,               // Serial value a
    input  logic in_b_rx,               // Serial value b
    output logic chain_a_tx,
    output logic chain_b_tx,
    output logic chain_c_tx,
    output logic y1_tx,
    output logic y2_tx,
    output logic chain_c_bit            // Raw third-stage bitstream
);
    import sc_pkg::*;

    value_t value_a;
    value_t value_b;
    lfsr_t  lfsr_state;
    logic   in_a_bit;
    logic   in_b_bit;
    logic   half1_bit;
    logic   half2_bit;
    value_t chain_a;
    value_t chain_b;
    value_t chain_c;
    value_t y1;
    value_t y2;

    serial_value_rx u_rx (
        .clk(clk), .rst_n(rst_n), .in_a_rx(in_a_rx), .in_b_rx(in_b_rx),
        .value_a(value_a), .value_b(value_b)
    );

    sng_bank u_sng (
        .clk(clk), .rst_n(rst_n), .value_a(value_a), .value_b(value_b),
        .lfsr_state(lfsr_state), .in_a_bit(in_a_bit), .in_b_bit(in_b_bit),
        .half1_bit(half1_bit), .half2_bit(half2_bit)
    );

    integrator_chain u_chain (
        .clk(clk), .rst_n(rst_n), .in_a_bit(in_a_bit), .in_b_bit(in_b_bit),
        .lfsr_state(lfsr_state), .chain_a(chain_a), .chain_b(chain_b),
        .chain_c(chain_c), .chain_c_bit(chain_c_bit)
    );

    // Depends on the LFSR only, not on the serial inputs
    ode_pair u_ode (
        .clk(clk), .rst_n(rst_n), .half1_bit(half1_bit), .half2_bit(half2_bit),
        .lfsr_state(lfsr_state), .y1(y1), .y2(y2)
    );

    snapshot_tx u_tx (
        .clk(clk), .rst_n(rst_n), .chain_a(chain_a), .chain_b(chain_b),
        .chain_c(chain_c), .y1(y1), .y2(y2), .chain_a_tx(chain_a_tx),
        .chain_b_tx(chain_b_tx), .chain_c_tx(chain_c_tx), .y1_tx(y1_tx), .y2_tx(y2_tx)
    );

endmodule

// File: snapshot_tx.sv
// Periodic snapshot of the five integrator counts, sent out as 10-slot serial frames
`timescale 1ns/1ps

module snapshot_tx (
    input  sc_pkg::value_t chain_a,
    input  sc_pkg::value_t chain_b,
    input  sc_pkg::value_t chain_c,
    input  sc_pkg::value_t y1,
    input  sc_pkg::value_t y2,
    input  logic           clk,
    input  logic           rst_n,
    output logic           chain_a_tx,
    output logic           chain_b_tx,
    output logic           chain_c_tx,
    output logic           y1_tx,
    output logic           y2_tx
);
    import sc_pkg::*;
    import link_pkg::*;

    value_t            val_in   [5];    // One lane per integrator
    value_t            snap_reg [5];    // Values held for transmission
    value_t            shift_q  [5];
    logic [4:0]        tx_q;            // Registered serial bits
    logic [SNAP_W-1:0] snap_cnt;
    logic [SLOT_W-1:0] slot_cnt;

    assign val_in[0] = chain_a;
    assign val_in[1] = chain_b;
    assign val_in[2] = chain_c;
    assign val_in[3] = y1;
    assign val_in[4] = y2;

    // Capture every SNAP_INTERVAL cycles, first on the edge after reset
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            snap_cnt <= '0;
            for (int i = 0; i < 5; i++) snap_reg[i] <= '0;
        end else begin
            snap_cnt <= (snap_cnt == SNAP_W'(SNAP_INTERVAL - 1)) ? '0 : snap_cnt + 1'b1;
            if (snap_cnt == '0) begin
                for (int i = 0; i < 5; i++) snap_reg[i] <= val_in[i];
            end
        end
    end

    // Frame sequencer, bit k leaves on the edge of slot k
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            slot_cnt <= '0;
            tx_q     <= '0;
        end else begin
            slot_cnt <= (slot_cnt == SLOT_W'(GAP_SLOT)) ? '0 : slot_cnt + 1'b1;
            for (int i = 0; i < 5; i++) begin
                if (slot_cnt == '0) tx_q[i] <= snap_reg[i][0];  // LSB straight from snapshot
                else if (slot_cnt == SLOT_W'(GAP_SLOT)) tx_q[i] <= 1'b0;
                else tx_q[i] <= shift_q[i][0];
            end
        end
    end

    // Shift registers reload at slot 0
    always_ff @(posedge clk) begin
        for (int i = 0; i < 5; i++) begin
            shift_q[i] <= (slot_cnt == '0) ? snap_reg[i] >> 1 : shift_q[i] >> 1;
        end
    end

    assign chain_a_tx = tx_q[0];
    assign chain_b_tx = tx_q[1];
    assign chain_c_tx = tx_q[2];
    assign y1_tx      = tx_q[3];
    assign y2_tx      = tx_q[4];

endmodule

// File: ode_pair.sv
// Cross-coupled integrators solving dy1/dt = y2 - 1/2 and dy2/dt = 1/2 - y1
`timescale 1ns/1ps

module ode_pair (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           half1_bit,       // Constant 1/2 subtracted from dy1
    input  logic           half2_bit,       // Constant 1/2 added to dy2
    input  sc_pkg::lfsr_t  lfsr_state,
    output sc_pkg::value_t y1,
    output sc_pkg::value_t y2
);
    import sc_pkg::*;

    logic y1_bit;
    logic y2_bit;

    // y1 starts at 0 and grows with y2
    sc_integrator #(.INIT(VALUE_MIN)) u_y1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .inc_bit (y2_bit),
        .dec_bit (half1_bit),
        .value   (y1)
    );

    // y2 starts at 1/2 and shrinks with y1
    sc_integrator #(.INIT(VALUE_HALF)) u_y2 (
        .clk     (clk),
        .rst_n   (rst_n),
        .inc_bit (half2_bit),
        .dec_bit (y1_bit),
        .value   (y2)
    );

    // Feedback streams, windows A and B as in the chain
    assign y1_bit = y1 > lfsr_state[WIN_A_LO +: VALUE_W];
    assign y2_bit = y2 > lfsr_state[WIN_B_LO +: VALUE_W];

endmodule

// File: integrator_chain.sv
// Three cascaded integrators that build t, t^2/2 and t^3/6 from the input streams
`timescale 1ns/1ps

module integrator_chain (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_a_bit,        // Drives the first stage
    input  logic           in_b_bit,        // Common decrement for all stages
    input  sc_pkg::lfsr_t  lfsr_state,
    output sc_pkg::value_t chain_a,         // ~ t
    output sc_pkg::value_t chain_b,         // ~ t^2/2
    output sc_pkg::value_t chain_c,         // ~ t^3/6
    output logic           chain_c_bit      // Raw stream of the last stage
);
    import sc_pkg::*;

    logic a_bit;
    logic b_bit;

    sc_integrator u_stage_a (
        .clk     (clk),
        .rst_n   (rst_n),
        .inc_bit (in_a_bit),
        .dec_bit (in_b_bit),
        .value   (chain_a)
    );

    sc_integrator u_stage_b (
        .clk     (clk),
        .rst_n   (rst_n),
        .inc_bit (a_bit),           // Integrates stage a
        .dec_bit (in_b_bit),
        .value   (chain_b)
    );

    sc_integrator u_stage_c (
        .clk     (clk),
        .rst_n   (rst_n),
        .inc_bit (b_bit),           // Integrates stage b
        .dec_bit (in_b_bit),
        .value   (chain_c)
    );

    // Each stage re-encoded on its own window
    assign a_bit       = chain_a > lfsr_state[WIN_A_LO +: VALUE_W];
    assign b_bit       = chain_b > lfsr_state[WIN_B_LO +: VALUE_W];
    assign chain_c_bit = chain_c > lfsr_state[WIN_C_LO +: VALUE_W];

endmodule

// File: sc_integrator.sv
// Saturating up/down counter that integrates the difference of two stochastic bitstreams
`timescale 1ns/1ps

module sc_integrator #(
    parameter sc_pkg::value_t INIT = '0     // Count at reset
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           inc_bit,         // Positive integrand stream
    input  logic           dec_bit,         // Negative integrand stream
    output sc_pkg::value_t value
);
    import sc_pkg::*;

    // One Euler step per cycle, equal bits cancel
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            value <= INIT;
        end else if (inc_bit && !dec_bit) begin
            if (value != VALUE_MAX) begin   // Hold at the top
                value <= value + 1'b1;
            end
        end else if (dec_bit && !inc_bit) begin
            if (value != VALUE_MIN) begin   // Hold at the bottom
                value <= value - 1'b1;
            end
        end
    end

endmodule

// File: sng_bank.sv
// LFSR and comparator bank producing the shared input and half-probability bitstreams
`timescale 1ns/1ps

module sng_bank (
    input  logic           clk,
    input  logic           rst_n,
    input  sc_pkg::value_t value_a,     // Probability of in_a_bit
    input  sc_pkg::value_t value_b,     // Probability of in_b_bit
    output sc_pkg::lfsr_t  lfsr_state,  // Shared with both integrator groups
    output logic           in_a_bit,
    output logic           in_b_bit,
    output logic           half1_bit,
    output logic           half2_bit
);
    import sc_pkg::*;

    // Fibonacci LFSR, one shift per cycle
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            lfsr_state <= LFSR_SEED;
        end else begin
            lfsr_state <= {lfsr_state[LFSR_W-2:0],
                           lfsr_state[LFSR_TAP_HI] ^ lfsr_state[LFSR_TAP_LO]};
        end
    end

    // Bit is 1 when the value exceeds its random window
    assign in_a_bit = value_a > lfsr_state[WIN_IN_A_LO +: VALUE_W];
    assign in_b_bit = value_b > lfsr_state[WIN_IN_B_LO +: VALUE_W];

    // Two half-probability streams on distinct windows
    // Separate windows keep them weakly correlated
    assign half1_bit = VALUE_HALF > lfsr_state[WIN_HALF1_LO +: VALUE_W];
    assign half2_bit = VALUE_HALF > lfsr_state[WIN_HALF2_LO +: VALUE_W];

endmodule

// File: serial_value_rx.sv
// Two-channel serial receiver that turns 10-slot frames into the 9-bit input probabilities
`timescale 1ns/1ps

module serial_value_rx (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_a_rx,     // Serial input a, LSB first
    input  logic           in_b_rx,     // Serial input b, LSB first
    output sc_pkg::value_t value_a,
    output sc_pkg::value_t value_b
);
    import sc_pkg::*;
    import link_pkg::*;

    logic [SLOT_W-1:0] slot_cnt;        // Position within the current frame
    value_t            shift_a;         // Words under assembly
    value_t            shift_b;

    // Slot counter and latched values
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            slot_cnt <= '0;
            value_a  <= VALUE_MAX;      // Full-scale a until the first frame lands
            value_b  <= VALUE_MIN;
        end else if (slot_cnt == SLOT_W'(GAP_SLOT)) begin
            slot_cnt <= '0;
            value_a  <= shift_a;        // Whole word present after slot 8
            value_b  <= shift_b;
        end else begin
            slot_cnt <= slot_cnt + 1'b1;
        end
    end

    // New bit enters at the top, so bit 0 ends at the bottom after nine shifts
    always_ff @(posedge clk) begin
        if (slot_cnt != SLOT_W'(GAP_SLOT)) begin
            shift_a <= {in_a_rx, shift_a[VALUE_W-1:1]};
            shift_b <= {in_b_rx, shift_b[VALUE_W-1:1]};
        end
    end

endmodule

// File: link_pkg.sv
// Serial frame format and snapshot timing shared by the input receiver and output transmitter
package link_pkg;

    // Frame layout
    // Nine data slots LSB first, then a gap slot that always carries 0
    localparam int FRAME_LEN = 10;
    localparam int GAP_SLOT  = FRAME_LEN - 1;

    // Slot counter covers 0..GAP_SLOT
    localparam int SLOT_W = 4;

    // Snapshot cadence
    localparam int SNAP_INTERVAL = 16;          // Cycles between captures
    localparam int SNAP_W        = 4;           // Counter wraps at SNAP_INTERVAL

endpackage

// File: sc_pkg.sv
// Stochastic-number widths, saturation limits, LFSR setup and comparator windows, imported by the SC datapath
package sc_pkg;

    // Stochastic value format
    localparam int VALUE_W = 9;
    typedef logic [VALUE_W-1:0] value_t;        // Unsigned probability, 0..511

    localparam value_t VALUE_MAX  = 9'd511;     // Upper saturation limit
    localparam value_t VALUE_MIN  = 9'd0;       // Lower saturation limit
    localparam value_t VALUE_HALF = 9'd256;     // Probability one half

    // Random source
    localparam int LFSR_W = 31;
    typedef logic [LFSR_W-1:0] lfsr_t;
    localparam lfsr_t LFSR_SEED   = 31'd134995;
    localparam int    LFSR_TAP_HI = 30;         // Feedback taps x^31 + x^28 + 1
    localparam int    LFSR_TAP_LO = 27;

    // Low bit of each 9-bit LFSR window used by the integrator comparators
    localparam int WIN_A_LO = 22;
    localparam int WIN_B_LO = 1;
    localparam int WIN_C_LO = 12;

    // Windows for the input and half-probability generators
    localparam int WIN_IN_A_LO  = 0;
    localparam int WIN_IN_B_LO  = 9;
    localparam int WIN_HALF1_LO = 5;
    localparam int WIN_HALF2_LO = 20;

endpackage
